// File: ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// register file and buffer sizes
////////////////////////////////////////////////////////////////////////////

`define ARF_COUNT   32      // architectural registers
`define PRF_COUNT   64      // physical registers
`define ROB_DEPTH   16
`define CDB_WIDTH   2       // number of CDB ports

// index widths
`define ARF_IDX     5
`define PRF_IDX     6
`define ROB_IDX     4

// registers not mapped at reset start out free
`define FREE_DEPTH  (`PRF_COUNT - `ARF_COUNT)

`endif

// File: ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

    // architectural register number
    typedef logic [`ARF_IDX-1:0] arf_idx_t;

    // physical register number
    typedef logic [`PRF_IDX-1:0] prf_idx_t;

    // reorder buffer entry number
    typedef logic [`ROB_IDX-1:0] rob_idx_t;

    typedef logic [31:0] word_t;    // result value

endpackage

// File: free_list.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module free_list (
    input  logic              clk,
    input  logic              rst,
    input  logic              pop,
    output ooo_pkg::prf_idx_t pop_phy,
    input  logic              push,
    input  ooo_pkg::prf_idx_t push_phy,
    output logic              empty
);

    localparam int FL_IDX = $clog2(`FREE_DEPTH);

    ooo_pkg::prf_idx_t  queue [`FREE_DEPTH];

    logic [FL_IDX:0]    head_ptr_reg;   // msb is the wrap flag
    logic [FL_IDX:0]    tail_ptr_reg;

    logic [FL_IDX-1:0]  head_ptr;
    logic [FL_IDX-1:0]  tail_ptr;

    assign head_ptr = head_ptr_reg[FL_IDX-1:0];
    assign tail_ptr = tail_ptr_reg[FL_IDX-1:0];

    // same index and same flag means nothing left
    assign empty   = (head_ptr_reg == tail_ptr_reg);
    assign pop_phy = queue[head_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            // starts full with the upper register numbers
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                queue[i] <= ooo_pkg::prf_idx_t'(`ARF_COUNT + i);
            end
            head_ptr_reg <= '0;
            tail_ptr_reg <= {1'b1, {FL_IDX{1'b0}}};
        end else begin
            if (pop && !empty) begin
                head_ptr_reg <= head_ptr_reg + 1'b1;
            end
            if (push) begin     // returned register from retirement
                queue[tail_ptr] <= push_phy;
                tail_ptr_reg    <= tail_ptr_reg + 1'b1;
            end
        end
    end

endmodule

// File: rename_table.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module rename_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  ooo_pkg::arf_idx_t wr_arch,
    input  ooo_pkg::prf_idx_t wr_phy,
    input  ooo_pkg::arf_idx_t rs1_arch,
    input  ooo_pkg::arf_idx_t rs2_arch,
    output ooo_pkg::prf_idx_t rs1_phy,
    output ooo_pkg::prf_idx_t rs2_phy
);

    // speculative arch -> phys map
    ooo_pkg::prf_idx_t  map [`ARF_COUNT];

    ////////////////////////////////////////////////////////////////////////////
    // source lookups
    ////////////////////////////////////////////////////////////////////////////

    // reads see the table before this cycle's rename
    assign rs1_phy = map[rs1_arch];
    assign rs2_phy = map[rs2_arch];

    ////////////////////////////////////////////////////////////////////////////
    // destination rename
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARF_COUNT; i++) begin
                map[i] <= ooo_pkg::prf_idx_t'(i);   // identity
            end
        end else if (we) begin
            map[wr_arch] <= wr_phy;
        end
    end

endmodule

// File: rename_stage.sv
`timescale 1ns/1ns

module rename_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid,
    input  ooo_pkg::arf_idx_t disp_rd_arch,
    input  ooo_pkg::arf_idx_t disp_rs1_arch,
    input  ooo_pkg::arf_idx_t disp_rs2_arch,
    input  logic              rob_full,
    input  logic              free_push,
    input  ooo_pkg::prf_idx_t free_phy,
    output logic              disp_ready,
    output ooo_pkg::prf_idx_t disp_rd_phy,
    output ooo_pkg::prf_idx_t disp_rs1_phy,
    output ooo_pkg::prf_idx_t disp_rs2_phy,
    output logic              rob_push
);

    logic free_empty;
    logic accept;

    // need a rob slot and a free register to take an instruction
    assign disp_ready = !rob_full && !free_empty;
    assign accept     = disp_valid && disp_ready;
    assign rob_push   = accept;

    free_list i_free_list (
        .clk      (clk),
        .rst      (rst),
        .pop      (accept),
        .pop_phy  (disp_rd_phy),    // head of the queue is the next rd
        .push     (free_push),
        .push_phy (free_phy),
        .empty    (free_empty)
    );

    rename_table i_rename_table (
        .clk      (clk),
        .rst      (rst),
        .we       (accept),
        .wr_arch  (disp_rd_arch),
        .wr_phy   (disp_rd_phy),
        .rs1_arch (disp_rs1_arch),
        .rs2_arch (disp_rs2_arch),
        .rs1_phy  (disp_rs1_phy),
        .rs2_phy  (disp_rs2_phy)
    );

endmodule

// File: rob.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module rob (
    input  logic              clk,
    input  logic              rst,

    input  logic              rob_push,
    input  ooo_pkg::arf_idx_t push_arch,
    input  ooo_pkg::prf_idx_t push_phy,
    output logic              rob_full,
    output ooo_pkg::rob_idx_t tail_id,

    input  logic              cdb_valid  [`CDB_WIDTH],
    input  ooo_pkg::rob_idx_t cdb_rob_id [`CDB_WIDTH],
    input  ooo_pkg::word_t    cdb_value  [`CDB_WIDTH],

    output logic              commit_valid,
    output ooo_pkg::arf_idx_t commit_arch,
    output ooo_pkg::prf_idx_t commit_phy,
    output ooo_pkg::word_t    commit_value,
    output logic [63:0]       commit_order
);

    logic               ready_array [`ROB_DEPTH];
    ooo_pkg::arf_idx_t  arch_array  [`ROB_DEPTH];
    ooo_pkg::prf_idx_t  phy_array   [`ROB_DEPTH];
    ooo_pkg::word_t     value_array [`ROB_DEPTH];

    logic [`ROB_IDX:0]  head_ptr_reg;
    logic [`ROB_IDX:0]  tail_ptr_reg;

    ooo_pkg::rob_idx_t  head_ptr;
    logic               head_ptr_flag;
    ooo_pkg::rob_idx_t  tail_ptr;
    logic               tail_ptr_flag;

    logic               empty;

    assign {head_ptr_flag, head_ptr} = head_ptr_reg;
    assign {tail_ptr_flag, tail_ptr} = tail_ptr_reg;

    // flags differ when the tail has lapped the head
    assign rob_full = (tail_ptr == head_ptr) && (tail_ptr_flag != head_ptr_flag);
    assign empty    = (tail_ptr == head_ptr) && (tail_ptr_flag == head_ptr_flag);
    assign tail_id  = tail_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // allocate, snoop, retire
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                ready_array[i] <= 1'b0;
            end
            head_ptr_reg <= '0;
            tail_ptr_reg <= '0;
            commit_order <= 64'd0;
        end else begin
            if (rob_push && !rob_full) begin
                tail_ptr_reg          <= tail_ptr_reg + 1'b1;
                ready_array[tail_ptr] <= 1'b0;
                arch_array[tail_ptr]  <= push_arch;
                phy_array[tail_ptr]   <= push_phy;
            end

            if (commit_valid) begin     // head leaves
                head_ptr_reg <= head_ptr_reg + 1'b1;
                commit_order <= commit_order + 64'd1;
            end

            // results arrive in any order
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (cdb_valid[k]) begin
                    ready_array[cdb_rob_id[k]] <= 1'b1;
                    value_array[cdb_rob_id[k]] <= cdb_value[k];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // commit port
    ////////////////////////////////////////////////////////////////////////////

    assign commit_valid = !empty && ready_array[head_ptr];
    assign commit_arch  = arch_array[head_ptr];
    assign commit_phy   = phy_array[head_ptr];
    assign commit_value = value_array[head_ptr];

endmodule

// File: retire_table.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module retire_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              commit_valid,
    input  ooo_pkg::arf_idx_t commit_arch,
    input  ooo_pkg::prf_idx_t commit_phy,
    output logic              free_push,
    output ooo_pkg::prf_idx_t free_phy
);

    // committed arch -> phys map
    ooo_pkg::prf_idx_t  map [`ARF_COUNT];

    ////////////////////////////////////////////////////////////////////////////
    // commit update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARF_COUNT; i++) begin
                map[i] <= ooo_pkg::prf_idx_t'(i);
            end
            free_push <= 1'b0;
        end else begin
            free_push <= commit_valid;
            if (commit_valid) begin
                map[commit_arch] <= commit_phy;
            end
        end
    end

    // the mapping being replaced is dead once the new one commits
    always_ff @(posedge clk) begin
        if (commit_valid) begin
            free_phy <= map[commit_arch];
        end
    end

endmodule

// File: ooo_backend.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_backend (
    input  logic              clk,
    input  logic              rst,

    input  logic              disp_valid,
    input  ooo_pkg::arf_idx_t disp_rd_arch,
    input  ooo_pkg::arf_idx_t disp_rs1_arch,
    input  ooo_pkg::arf_idx_t disp_rs2_arch,
    output logic              disp_ready,
    output ooo_pkg::rob_idx_t disp_rob_id,
    output ooo_pkg::prf_idx_t disp_rd_phy,
    output ooo_pkg::prf_idx_t disp_rs1_phy,
    output ooo_pkg::prf_idx_t disp_rs2_phy,

    input  logic              cdb_valid  [`CDB_WIDTH],
    input  ooo_pkg::rob_idx_t cdb_rob_id [`CDB_WIDTH],
    input  ooo_pkg::word_t    cdb_value  [`CDB_WIDTH],

    output logic              commit_valid,
    output ooo_pkg::arf_idx_t commit_arch,
    output ooo_pkg::prf_idx_t commit_phy,
    output ooo_pkg::word_t    commit_value,
    output logic [63:0]       commit_order
);

    logic               rob_full;
    logic               rob_push;
    logic               free_push;  // freed register loop from retirement
    ooo_pkg::prf_idx_t  free_phy;

    rename_stage i_rename_stage (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_rd_arch  (disp_rd_arch),
        .disp_rs1_arch (disp_rs1_arch),
        .disp_rs2_arch (disp_rs2_arch),
        .rob_full      (rob_full),
        .free_push     (free_push),
        .free_phy      (free_phy),
        .disp_ready    (disp_ready),
        .disp_rd_phy   (disp_rd_phy),
        .disp_rs1_phy  (disp_rs1_phy),
        .disp_rs2_phy  (disp_rs2_phy),
        .rob_push      (rob_push)
    );

    rob i_rob (
        .clk          (clk),
        .rst          (rst),
        .rob_push     (rob_push),
        .push_arch    (disp_rd_arch),
        .push_phy     (disp_rd_phy),
        .rob_full     (rob_full),
        .tail_id      (disp_rob_id),
        .cdb_valid    (cdb_valid),
        .cdb_rob_id   (cdb_rob_id),
        .cdb_value    (cdb_value),
        .commit_valid (commit_valid),
        .commit_arch  (commit_arch),
        .commit_phy   (commit_phy),
        .commit_value (commit_value),
        .commit_order (commit_order)
    );

    retire_table i_retire_table (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_arch  (commit_arch),
        .commit_phy   (commit_phy),
        .free_push    (free_push),
        .free_phy     (free_phy)
    );

endmodule

// File: tb_ooo_backend.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module tb_ooo_backend;

    logic clk;
    logic rst;
    logic disp_valid, disp_ready, commit_valid;
    ooo_pkg::arf_idx_t disp_rd_arch, disp_rs1_arch, disp_rs2_arch, commit_arch;
    ooo_pkg::rob_idx_t disp_rob_id;
    ooo_pkg::prf_idx_t disp_rd_phy, disp_rs1_phy, disp_rs2_phy, commit_phy;
    logic              cdb_valid  [`CDB_WIDTH];
    ooo_pkg::rob_idx_t cdb_rob_id [`CDB_WIDTH];
    ooo_pkg::word_t    cdb_value  [`CDB_WIDTH];
    ooo_pkg::word_t    commit_value;
    logic [63:0]       commit_order;

    // reference model
    integer seed;
    int errors, accepted, alloc_cnt;
    bit timed_out, pend_acc, pend_com, pend_free;
    ooo_pkg::prf_idx_t free_q [$];
    ooo_pkg::prf_idx_t spec_map [`ARF_COUNT];
    ooo_pkg::prf_idx_t comm_map [`ARF_COUNT];
    ooo_pkg::prf_idx_t free_hold;               // freed at the last commit
    logic [`PRF_COUNT-1:0] phy_live;
    ooo_pkg::arf_idx_t q_arch [$];
    ooo_pkg::prf_idx_t q_phy [$];
    ooo_pkg::rob_idx_t q_id [$];
    bit is_sent [`ROB_DEPTH];
    bit is_done [`ROB_DEPTH];
    ooo_pkg::word_t val_by_id [`ROB_DEPTH];

    // expected outputs held from 2 ns after one edge to the next
    logic exp_ready, exp_cvalid;
    ooo_pkg::rob_idx_t exp_rob_id;
    ooo_pkg::prf_idx_t exp_rd_phy, exp_rs1_phy, exp_rs2_phy, exp_cphy;
    ooo_pkg::arf_idx_t exp_carch;
    ooo_pkg::word_t exp_cvalue;
    logic [63:0] exp_order;

    ooo_backend i_ooo_backend (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    function automatic void report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        errors++;
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    endfunction

    assert property (@(posedge clk) disable iff (rst) disp_ready == exp_ready)
        else report_mismatch("disp_ready", $sampled(disp_ready), $sampled(exp_ready));
    assert property (@(posedge clk) disable iff (rst)
        disp_valid && disp_ready |-> disp_rob_id == exp_rob_id)
        else report_mismatch("disp_rob_id", $sampled(disp_rob_id), $sampled(exp_rob_id));
    assert property (@(posedge clk) disable iff (rst)
        disp_valid && disp_ready |-> disp_rd_phy == exp_rd_phy)
        else report_mismatch("disp_rd_phy", $sampled(disp_rd_phy), $sampled(exp_rd_phy));
    assert property (@(posedge clk) disable iff (rst)
        disp_valid && disp_ready |-> !phy_live[disp_rd_phy])
        else begin
            errors++;
            $display("physical register %h handed out while still live", $sampled(disp_rd_phy));
        end
    assert property (@(posedge clk) disable iff (rst) disp_rs1_phy == exp_rs1_phy)
        else report_mismatch("disp_rs1_phy", $sampled(disp_rs1_phy), $sampled(exp_rs1_phy));
    assert property (@(posedge clk) disable iff (rst) disp_rs2_phy == exp_rs2_phy)
        else report_mismatch("disp_rs2_phy", $sampled(disp_rs2_phy), $sampled(exp_rs2_phy));
    assert property (@(posedge clk) disable iff (rst) commit_valid == exp_cvalid)
        else report_mismatch("commit_valid", $sampled(commit_valid), $sampled(exp_cvalid));
    assert property (@(posedge clk) disable iff (rst) commit_valid |-> commit_arch == exp_carch)
        else report_mismatch("commit_arch", $sampled(commit_arch), $sampled(exp_carch));
    assert property (@(posedge clk) disable iff (rst) commit_valid |-> commit_phy == exp_cphy)
        else report_mismatch("commit_phy", $sampled(commit_phy), $sampled(exp_cphy));
    assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_value == exp_cvalue)
        else report_mismatch("commit_value", $sampled(commit_value), $sampled(exp_cvalue));
    assert property (@(posedge clk) disable iff (rst) commit_order == exp_order)
        else report_mismatch("commit_order", $sampled(commit_order), $sampled(exp_order));

    ////////////////////////////////////////////////////////////////////////////
    // model update and stimulus
    ////////////////////////////////////////////////////////////////////////////

    // events of the edge just passed; inputs still hold last cycle's values
    task automatic apply_events();
        ooo_pkg::rob_idx_t id;
        if (pend_free) begin                    // return lands one edge after commit
            free_q.push_back(free_hold);
            phy_live[free_hold] = 1'b0;
        end
        pend_free = pend_com;
        if (pend_com) begin
            free_hold = comm_map[q_arch[0]];
            comm_map[q_arch[0]] = q_phy[0];
            void'(q_arch.pop_front());
            void'(q_phy.pop_front());
            void'(q_id.pop_front());
            exp_order++;
        end
        if (pend_acc) begin
            id = ooo_pkg::rob_idx_t'(alloc_cnt);
            spec_map[disp_rd_arch] = free_q[0];
            phy_live[free_q[0]] = 1'b1;
            q_arch.push_back(disp_rd_arch);
            q_phy.push_back(free_q.pop_front());
            q_id.push_back(id);
            is_sent[id] = 1'b0;
            is_done[id] = 1'b0;
            alloc_cnt++;
        end
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (cdb_valid[k]) is_done[cdb_rob_id[k]] = 1'b1;
        end
    endtask

    // cdb_mode 0 no results, 1 head only, 2 random entries
    task automatic drive_inputs(input bit want_disp, input int cdb_mode);
        int r;
        int pick;
        ooo_pkg::rob_idx_t id;
        r = $random(seed);
        disp_valid    = want_disp;
        disp_rd_arch  = r[4:0];
        disp_rs1_arch = r[9:5];
        disp_rs2_arch = r[14:10];
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            cdb_valid[k] = 1'b0;
            r = $random(seed);
            if (cdb_mode != 0 && q_id.size() > 0) begin
                pick = (cdb_mode == 1) ? 0 : int'(r[15:0]) % q_id.size();
                id = q_id[pick];
                if (!is_sent[id] && r[20]) begin    // sent flag keeps the ports distinct
                    is_sent[id]   = 1'b1;
                    val_by_id[id] = r;
                    cdb_valid[k]  = 1'b1;
                    cdb_rob_id[k] = id;
                    cdb_value[k]  = r;
                end
            end
        end
    endtask

    task automatic update_expect();
        exp_ready   = (q_id.size() < `ROB_DEPTH) && (free_q.size() > 0);
        exp_rob_id  = ooo_pkg::rob_idx_t'(alloc_cnt);
        exp_rd_phy  = (free_q.size() > 0) ? free_q[0] : '0;
        exp_rs1_phy = spec_map[disp_rs1_arch];
        exp_rs2_phy = spec_map[disp_rs2_arch];
        exp_cvalid  = 1'b0;
        if (q_id.size() > 0) begin
            exp_cvalid = is_done[q_id[0]];
            exp_carch  = q_arch[0];
            exp_cphy   = q_phy[0];
            exp_cvalue = val_by_id[q_id[0]];
        end
    endtask

    task automatic run_cycle(input bit want_disp, input int cdb_mode);
        @(posedge clk);
        #2;
        apply_events();
        drive_inputs(want_disp, cdb_mode);
        update_expect();
        pend_acc = disp_valid && exp_ready;
        pend_com = exp_cvalid;
        if (pend_acc) accepted++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic drain_rob(input string name);
        int n;
        n = 0;
        while ((q_id.size() > 0 || pend_acc || pend_com) && n < 400) begin
            run_cycle(1'b0, 2);
            n++;
        end
        if (q_id.size() > 0 || pend_acc || pend_com) begin
            $display("timeout: reorder buffer did not drain in test %s", name);
            timed_out = 1'b1;
        end
        $display("test %s done, %0d errors so far", name, errors);
    endtask

    task automatic dispatch_run(input string name, input int count);
        int n;
        int start;
        int r;
        if (timed_out) return;
        n = 0;
        start = accepted;
        while (accepted - start < count && n < 20 * count) begin
            r = $random(seed);
            run_cycle(r[1:0] != 2'd0, 2);
            n++;
        end
        if (accepted - start < count) begin
            $display("timeout: only %0d of %0d dispatched in test %s",
                     accepted - start, count, name);
            timed_out = 1'b1;
        end
        drain_rob(name);
    endtask

    task automatic back_pressure();
        int n;
        if (timed_out) return;
        n = 0;
        while (q_id.size() < `ROB_DEPTH && n < 100) begin
            run_cycle(1'b1, 0);
            n++;
        end
        if (q_id.size() < `ROB_DEPTH) begin
            $display("timeout: reorder buffer did not fill in test back_pressure");
            timed_out = 1'b1;
        end
        repeat (4) run_cycle(1'b1, 0);      // held valid against a full buffer
        n = 0;
        while (n < 50) begin
            run_cycle(1'b1, 1);
            #1;
            if (disp_ready) break;
            n++;
        end
        if (n == 50) begin
            $display("timeout: disp_ready stayed low after the head completed");
            timed_out = 1'b1;
        end
        drain_rob("back_pressure");
    endtask

    initial begin
        seed = 25;
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_rd_arch = '0;
        disp_rs1_arch = '0;
        disp_rs2_arch = '0;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            cdb_valid[k] = 1'b0;
            cdb_rob_id[k] = '0;
            cdb_value[k] = '0;
        end
        for (int i = 0; i < `ARF_COUNT; i++) begin
            spec_map[i] = ooo_pkg::prf_idx_t'(i);
            comm_map[i] = ooo_pkg::prf_idx_t'(i);
            free_q.push_back(ooo_pkg::prf_idx_t'(`ARF_COUNT + i));
        end
        phy_live = {{`FREE_DEPTH{1'b0}}, {`ARF_COUNT{1'b1}}};
        exp_order = '0;
        update_expect();
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        repeat (2) run_cycle(1'b0, 0);
        $display("test reset_state done, %0d errors so far", errors);
        dispatch_run("rename_retire", 40);
        back_pressure();
        dispatch_run("recycling", 200);
        $display("summary: %0d dispatched, %0d committed, %0d errors, timeout %0d",
                 accepted, exp_order, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
ooo_pkg.sv
free_list.sv
rename_table.sv
rename_stage.sv
rob.sv
retire_table.sv
ooo_backend.sv
tb_ooo_backend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the backend testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ooo_backend -f list.f -o sim_ooo_backend

./obj_dir/sim_ooo_backend | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"
